/* source/flag_pkg.sv */
package flag_pkg;

   //////////////////////////////
   // Bus addresses
   //////////////////////////////

   // Both addresses select the one flag register
   // They sit on decoder outputs 5 and 6 with bit 3 high and bit 4 low
   localparam logic [4:0] addr_flags_mbp = 5'd13;
   localparam logic [4:0] addr_flags     = 5'd14;

   //////////////////////////////
   // Action codes
   //////////////////////////////

   // An action code is only decoded while its top bit is clear
   localparam int unsigned action_nen_bit = 3;

   localparam logic [3:0] action_cpl = 4'd1;
   localparam logic [3:0] action_cll = 4'd2;
   localparam logic [3:0] action_sti = 4'd3;
   localparam logic [3:0] action_cli = 4'd4;

   // ALU operation select
   localparam logic alu_op_add = 1'b0;
   localparam logic alu_op_sub = 1'b1;

   // Default datapath width of the processor
   localparam int unsigned alu_width_default = 16;

   // Positions of the writable flags on the internal bus
   localparam int unsigned ibus_bit_fi = 15;
   localparam int unsigned ibus_bit_fv = 13;
   localparam int unsigned ibus_bit_fl = 12;

   //////////////////////////////
   // Flag byte
   //////////////////////////////

   // The same byte drives the bus high half and the lamps
   // Fields are listed from the most significant bit down
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       fi;
         logic       rsvd;
         logic       fv;
         logic       fl;
         logic       fz;
         logic       fn;
         logic [1:0] rsvd2;
      } f;
   } flag_byte_u;

endpackage

/* source/flag_unit.sv */
module flag_unit (
   input  logic [4:0]  waddr,
   input  logic [4:0]  raddr,
   input  logic [3:0]  action,
   input  logic        nfpflags,
   input  logic        fn,
   input  logic        fz,
   input  logic        fl,
   input  logic        fv,
   input  logic        fi,
   output logic [15:0] ibus_out,
   output logic        ibus_oe,
   output logic [7:0]  fpd,
   output logic        nflagwe,
   output logic        naction_cpl,
   output logic        naction_cll,
   output logic        naction_sti,
   output logic        naction_cli
);

   // Works like one 138 decoder with a single active high enable
   // The selected output goes low and all others stay high
   function automatic logic [7:0] decode_138(input logic [2:0] sel, input logic en);
      logic [7:0] y;
      y = 8'hff;
      if (en) begin
         y[sel] = 1'b0;
      end
      return y;
   endfunction

   logic [7:0] wy;
   logic [7:0] ry;
   logic [7:0] ay;
   logic       nflagoe;

   flag_pkg::flag_byte_u flag_byte;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   // Register space 8 to 15 is enabled by bit 3 high and bit 4 low
   assign wy = decode_138(waddr[2:0], waddr[3] & ~waddr[4]);
   assign ry = decode_138(raddr[2:0], raddr[3] & ~raddr[4]);

   // Either flag address writes the register, so the strobes are merged low
   assign nflagwe = wy[flag_pkg::addr_flags_mbp[2:0]] & wy[flag_pkg::addr_flags[2:0]];

   // The read enable is built the same way from the read decoder
   assign nflagoe = ry[flag_pkg::addr_flags_mbp[2:0]] & ry[flag_pkg::addr_flags[2:0]];
   assign ibus_oe = ~nflagoe;

   //////////////////////////////
   // Action decode
   //////////////////////////////

   // Codes with the top bit set disable the whole decoder
   assign ay = decode_138(action[2:0], ~action[flag_pkg::action_nen_bit]);

   assign naction_cpl = ay[flag_pkg::action_cpl[2:0]];
   assign naction_cll = ay[flag_pkg::action_cll[2:0]];
   assign naction_sti = ay[flag_pkg::action_sti[2:0]];
   assign naction_cli = ay[flag_pkg::action_cli[2:0]];

   //////////////////////////////
   // Flag byte drive
   //////////////////////////////

   // Reserved bits are not modelled and always read as zero
   always_comb begin
      flag_byte.raw   = 8'h00;
      flag_byte.f.fi  = fi;
      flag_byte.f.fv  = fv;
      flag_byte.f.fl  = fl;
      flag_byte.f.fz  = fz;
      flag_byte.f.fn  = fn;
   end

   // The flags occupy only the high half of the internal bus
   // A released bus reads as all zero
   assign ibus_out = ibus_oe ? {flag_byte.raw, 8'h00} : 16'h0000;

   // Lamps share the bus bit layout and go dark while the panel is deselected
   assign fpd = nfpflags ? 8'h00 : flag_byte.raw;

   // Writing is not done here
   // Only nflagwe leaves this block and the flag register takes the bus itself

endmodule

/* source/flag_register.sv */
module flag_register (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] ibus_in,
   input  logic        nflagwe,
   input  logic        naction_cpl,
   input  logic        naction_cll,
   input  logic        naction_sti,
   input  logic        naction_cli,
   input  logic        alu_strobe,
   input  logic        new_fn,
   input  logic        new_fz,
   input  logic        new_fl,
   input  logic        new_fv,
   output logic        fn,
   output logic        fz,
   output logic        fl,
   output logic        fv,
   output logic        fi
);

   logic fn_next;
   logic fz_next;
   logic fl_next;
   logic fv_next;
   logic fi_next;

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      // Every flag holds unless one of its sources is active
      fn_next = fn;
      fz_next = fz;
      fl_next = fl;
      fv_next = fv;
      fi_next = fi;

      // Link has four sources and the bus write is strongest
      // Complement wins over clear, and the ALU only lands when nothing else does
      if (!nflagwe) begin
         fl_next = ibus_in[flag_pkg::ibus_bit_fl];
      end else if (!naction_cpl) begin
         fl_next = ~fl;
      end else if (!naction_cll) begin
         fl_next = 1'b0;
      end else if (alu_strobe) begin
         fl_next = new_fl;
      end

      // Interrupt enable is set or cleared by actions unless the bus writes it
      if (!nflagwe) begin
         fi_next = ibus_in[flag_pkg::ibus_bit_fi];
      end else if (!naction_sti) begin
         fi_next = 1'b1;
      end else if (!naction_cli) begin
         fi_next = 1'b0;
      end

      // Overflow comes from the bus first and then from the ALU
      if (!nflagwe) begin
         fv_next = ibus_in[flag_pkg::ibus_bit_fv];
      end else if (alu_strobe) begin
         fv_next = new_fv;
      end

      // Negative and zero cannot be written from the bus
      if (alu_strobe) begin
         fn_next = new_fn;
         fz_next = new_fz;
      end
   end

   //////////////////////////////
   // Flag flip-flops
   //////////////////////////////

   // All five flags read zero after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fn <= 1'b0;
         fz <= 1'b0;
         fl <= 1'b0;
         fv <= 1'b0;
         fi <= 1'b0;
      end else begin
         fn <= fn_next;
         fz <= fz_next;
         fl <= fl_next;
         fv <= fv_next;
         fi <= fi_next;
      end
   end

endmodule

/* source/alu_flag_gen.sv */
module alu_flag_gen #(
   parameter int unsigned alu_width = flag_pkg::alu_width_default
) (
   input  logic [alu_width-1:0] alu_a,
   input  logic [alu_width-1:0] alu_b,
   input  logic                 alu_op,
   output logic [alu_width-1:0] alu_result,
   output logic                 new_fn,
   output logic                 new_fz,
   output logic                 new_fl,
   output logic                 new_fv
);

   // Top bit index of the datapath
   localparam int unsigned msb = alu_width - 1;

   logic                 is_sub;
   logic [alu_width-1:0] b_eff;
   logic [alu_width-1:0] carry_in;
   logic [alu_width:0]   sum_ext;

   //////////////////////////////
   // Adder
   //////////////////////////////

   // Subtract is done as a plus the inverse of b plus one
   assign is_sub = (alu_op == flag_pkg::alu_op_sub);
   assign b_eff  = is_sub ? ~alu_b : alu_b;

   // The one for subtract enters as the carry into bit 0
   assign carry_in = {{(alu_width - 1){1'b0}}, is_sub};

   // One extra bit on the left catches the carry out
   assign sum_ext = {1'b0, alu_a} + {1'b0, b_eff} + {1'b0, carry_in};

   assign alu_result = sum_ext[msb:0];

   //////////////////////////////
   // Flag candidates
   //////////////////////////////

   // Link is the raw carry out in both modes
   // After subtract it reads as not borrow
   assign new_fl = sum_ext[alu_width];

   // Negative is simply the sign bit of the result
   assign new_fn = alu_result[msb];

   // Zero flag when no bit of the result is set
   assign new_fz = (alu_result == '0);

   // Overflow when both effective operands have one sign
   // and the result comes out with the other sign
   assign new_fv = (alu_a[msb] == b_eff[msb]) && (alu_result[msb] != alu_a[msb]);

   // These candidates are only taken into the flags under the ALU strobe
   // The result itself is always live

endmodule

/* source/flag_section.sv */
module flag_section #(
   parameter int unsigned alu_width = flag_pkg::alu_width_default
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [4:0]           waddr,
   input  logic [4:0]           raddr,
   input  logic [3:0]           action,
   input  logic [15:0]          ibus_in,
   input  logic                 nfpflags,
   input  logic [alu_width-1:0] alu_a,
   input  logic [alu_width-1:0] alu_b,
   input  logic                 alu_op,
   input  logic                 alu_strobe,
   output logic [15:0]          ibus_out,
   output logic                 ibus_oe,
   output logic [7:0]           fpd,
   output logic                 nflagwe,
   output logic [alu_width-1:0] alu_result
);

   // Flag state shared by the decode and storage blocks
   logic fn;
   logic fz;
   logic fl;
   logic fv;
   logic fi;

   // Active low action strobes
   logic naction_cpl;
   logic naction_cll;
   logic naction_sti;
   logic naction_cli;

   // Flag candidates from the ALU
   logic new_fn;
   logic new_fz;
   logic new_fl;
   logic new_fv;

   //////////////////////////////
   // Decode and bus drive
   //////////////////////////////

   flag_unit u_flag_unit (
      .waddr       (waddr),
      .raddr       (raddr),
      .action      (action),
      .nfpflags    (nfpflags),
      .fn          (fn),
      .fz          (fz),
      .fl          (fl),
      .fv          (fv),
      .fi          (fi),
      .ibus_out    (ibus_out),
      .ibus_oe     (ibus_oe),
      .fpd         (fpd),
      .nflagwe     (nflagwe),
      .naction_cpl (naction_cpl),
      .naction_cll (naction_cll),
      .naction_sti (naction_sti),
      .naction_cli (naction_cli)
   );

   //////////////////////////////
   // Flag storage
   //////////////////////////////

   flag_register u_flag_register (
      .clk         (clk),
      .rst_n       (rst_n),
      .ibus_in     (ibus_in),
      .nflagwe     (nflagwe),
      .naction_cpl (naction_cpl),
      .naction_cll (naction_cll),
      .naction_sti (naction_sti),
      .naction_cli (naction_cli),
      .alu_strobe  (alu_strobe),
      .new_fn      (new_fn),
      .new_fz      (new_fz),
      .new_fl      (new_fl),
      .new_fv      (new_fv),
      .fn          (fn),
      .fz          (fz),
      .fl          (fl),
      .fv          (fv),
      .fi          (fi)
   );

   // The datapath width is set here and handed down
   alu_flag_gen #(
      .alu_width (alu_width)
   ) u_alu_flag_gen (
      .alu_a      (alu_a),
      .alu_b      (alu_b),
      .alu_op     (alu_op),
      .alu_result (alu_result),
      .new_fn     (new_fn),
      .new_fz     (new_fz),
      .new_fl     (new_fl),
      .new_fv     (new_fv)
   );

endmodule

/* testbench/flag_section_asserts.sv */
module flag_section_asserts (
   input logic       clk,
   input logic       rst_n,
   input logic [4:0] waddr,
   input logic [4:0] raddr,
   input logic       nfpflags,
   input logic [7:0] fpd,
   input logic       ibus_oe,
   input logic       nflagwe,
   input logic       naction_cpl,
   input logic       naction_cll,
   input logic       naction_sti,
   input logic       naction_cli
);
   timeunit 1ns;
   timeprecision 1ps;

   logic wsel;
   logic rsel;

   // Either of the two flag addresses selects the register
   assign wsel = (waddr == flag_pkg::addr_flags_mbp) || (waddr == flag_pkg::addr_flags);
   assign rsel = (raddr == flag_pkg::addr_flags_mbp) || (raddr == flag_pkg::addr_flags);

   one_action_a: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({~naction_cpl, ~naction_cll, ~naction_sti, ~naction_cli}))
      else $error("More than one action strobe is active");

   read_enable_a: assert property (@(posedge clk) disable iff (!rst_n) ibus_oe == rsel)
      else $error("ibus_oe does not follow the read address");

   // Lamps stay dark while the panel is deselected
   panel_dark_a: assert property (@(posedge clk) disable iff (!rst_n) nfpflags |-> fpd == 8'h00)
      else $error("fpd is driven while nfpflags is high");

   write_strobe_a: assert property (@(posedge clk) disable iff (!rst_n) nflagwe == !wsel)
      else $error("nflagwe does not follow the write address");

endmodule

bind flag_section flag_section_asserts u_flag_section_asserts (
   .clk(clk), .rst_n(rst_n), .waddr(waddr), .raddr(raddr), .nfpflags(nfpflags),
   .fpd(fpd), .ibus_oe(ibus_oe), .nflagwe(nflagwe), .naction_cpl(naction_cpl),
   .naction_cll(naction_cll), .naction_sti(naction_sti), .naction_cli(naction_cli)
);

/* testbench/tb_flag_section.sv */
module tb_flag_section;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int width = 16;
   localparam int period = 20;

   // Cycle budget of reset, bus writes, actions, ALU pairs and randoms, priority and panel
   localparam int total_cycles = 4 + 8 + 26 + 36 + 144 + 8 + 8;

   logic             clk;
   logic             rst_n;
   logic [4:0]       waddr;
   logic [4:0]       raddr;
   logic [3:0]       action;
   logic [15:0]      ibus_in;
   logic             nfpflags;
   logic [width-1:0] alu_a;
   logic [width-1:0] alu_b;
   logic             alu_op;
   logic             alu_strobe;
   logic [15:0]      ibus_out;
   logic             ibus_oe;
   logic [7:0]       fpd;
   logic             nflagwe;
   logic [width-1:0] alu_result;

   // Reference copy of the five flags
   logic m_fn, m_fz, m_fl, m_fv, m_fi;

   int     errors;
   int     checks;
   integer seed;

   flag_section #(.alu_width(width)) UUT (
      .clk(clk), .rst_n(rst_n), .waddr(waddr), .raddr(raddr), .action(action),
      .ibus_in(ibus_in), .nfpflags(nfpflags), .alu_a(alu_a), .alu_b(alu_b),
      .alu_op(alu_op), .alu_strobe(alu_strobe), .ibus_out(ibus_out), .ibus_oe(ibus_oe),
      .fpd(fpd), .nflagwe(nflagwe), .alu_result(alu_result)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Stops a run that never reaches its verdict
   initial begin
      #(total_cycles * period * 2);
      $display("Timeout: the tests did not finish within %0d clock cycles", total_cycles * 2);
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic compare_values(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Inputs change 2 ns after the edge and are sampled 8 ns later
   task automatic wait_drive_point();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_sample_point();
      #8;
   endtask

   task automatic idle_inputs(input logic [4:0] rd);
      waddr      = 5'd0;
      raddr      = rd;
      action     = 4'd8;
      ibus_in    = 16'h0000;
      alu_strobe = 1'b0;
      nfpflags   = 1'b1;
   endtask

   // Expected ALU outputs from plain unsigned and signed integer arithmetic
   task automatic predict_alu(input logic [15:0] a, input logic [15:0] b, input logic op,
                              output logic [15:0] r, output logic n, output logic z,
                              output logic l, output logic v);
      int ua, ub, sa, sb, sr;
      ua = a;
      ub = b;
      sa = $signed(a);
      sb = $signed(b);
      if (op == flag_pkg::alu_op_add) begin
         r  = a + b;
         l  = (ua + ub) > 32'hffff;
         sr = sa + sb;
      end else begin
         // Carry after subtract means no borrow
         r  = a - b;
         l  = (ua >= ub);
         sr = sa - sb;
      end
      n = r[15];
      z = (r == 16'h0000);
      v = (sr > 32767) || (sr < -32768);
   endtask

   function automatic logic action_hit(input logic [3:0] code);
      return (action[3] == 1'b0) && (action == code);
   endfunction

   // Steps the reference flags with the inputs that the next edge will take
   task automatic advance_model();
      logic        wr;
      logic [15:0] r;
      logic        n, z, l, v;
      wr = (waddr == flag_pkg::addr_flags_mbp) || (waddr == flag_pkg::addr_flags);
      predict_alu(alu_a, alu_b, alu_op, r, n, z, l, v);
      if (wr) m_fl = ibus_in[12];
      else if (action_hit(flag_pkg::action_cpl)) m_fl = ~m_fl;
      else if (action_hit(flag_pkg::action_cll)) m_fl = 1'b0;
      else if (alu_strobe) m_fl = l;
      if (wr) m_fi = ibus_in[15];
      else if (action_hit(flag_pkg::action_sti)) m_fi = 1'b1;
      else if (action_hit(flag_pkg::action_cli)) m_fi = 1'b0;
      if (wr) m_fv = ibus_in[13];
      else if (alu_strobe) m_fv = v;
      if (alu_strobe) begin
         m_fn = n;
         m_fz = z;
      end
   endtask

   function automatic logic [7:0] model_byte();
      flag_pkg::flag_byte_u fb;
      fb.raw  = 8'h00;
      fb.f.fi = m_fi;
      fb.f.fv = m_fv;
      fb.f.fl = m_fl;
      fb.f.fz = m_fz;
      fb.f.fn = m_fn;
      return fb.raw;
   endfunction

   task automatic check_bus_flags(input string name);
      compare_values(name, {model_byte(), 8'h00}, ibus_out);
      compare_values({name, " oe"}, 16'd1, ibus_oe);
   endtask

   // Lets the edge take the current inputs, then reads the flags back
   task automatic clock_and_read(input string name);
      wait_sample_point();
      advance_model();
      wait_drive_point();
      idle_inputs(flag_pkg::addr_flags);
      wait_sample_point();
      check_bus_flags(name);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic check_reset_idle();
      logic [4:0] rd [0:3] = '{5'd13, 5'd14, 5'd12, 5'd15};
      for (int i = 0; i < 4; i++) begin
         wait_drive_point();
         raddr = rd[i];
         wait_sample_point();
         compare_values($sformatf("reset raddr %0d", rd[i]), 16'h0000, ibus_out);
         compare_values($sformatf("reset oe %0d", rd[i]), (i < 2) ? 16'd1 : 16'd0, ibus_oe);
         compare_values("reset nflagwe", 16'd1, nflagwe);
      end
   endtask

   task automatic bus_write_readback();
      logic [15:0] pats [0:4] = '{16'hb000, 16'h4fff, 16'hffff, 16'h2000, 16'h9000};
      logic [4:0]  other [0:2] = '{5'd12, 5'd15, 5'd29};
      for (int p = 0; p < 5; p++) begin
         for (int a = 0; a < 2; a++) begin
            wait_drive_point();
            waddr   = a ? flag_pkg::addr_flags : flag_pkg::addr_flags_mbp;
            ibus_in = pats[p];
            #1 compare_values("write nflagwe", 16'd0, nflagwe);
            clock_and_read($sformatf("write %h to %0d", pats[p], waddr));
         end
      end
      // Neighbouring addresses must leave the flags alone
      for (int i = 0; i < 3; i++) begin
         wait_drive_point();
         waddr   = other[i];
         ibus_in = ~{model_byte(), 8'h00};
         #1 compare_values("neighbour nflagwe", 16'd1, nflagwe);
         clock_and_read($sformatf("write to %0d", other[i]));
      end
   endtask

   // Disabled codes are applied where their enabled twin would change a flag
   task automatic apply_actions();
      logic [3:0] codes [0:17] = '{4'd1, 4'd1, 4'd2, 4'd3, 4'd4, 4'd9, 4'd11, 4'd0, 4'd5,
                                   4'd6, 4'd7, 4'd1, 4'd3, 4'd10, 4'd12, 4'd13, 4'd15, 4'd8};
      for (int i = 0; i < 18; i++) begin
         wait_drive_point();
         action = codes[i];
         clock_and_read($sformatf("action %0d step %0d", codes[i], i));
      end
   endtask

   task automatic alu_flag_updates();
      logic [15:0] corner [0:3] = '{16'h0000, 16'hffff, 16'h7fff, 16'h8000};
      logic [15:0] r;
      logic        n, z, l, v;
      for (int k = 0; k < 72; k++) begin
         wait_drive_point();
         if (k < 32) begin
            alu_a  = corner[k[4:3]];
            alu_b  = corner[k[2:1]];
            alu_op = k[0];
         end else begin
            alu_a  = $random(seed);
            alu_b  = $random(seed);
            alu_op = $random(seed);
         end
         alu_strobe = 1'b1;
         #1 predict_alu(alu_a, alu_b, alu_op, r, n, z, l, v);
         compare_values($sformatf("alu result %0d", k), r, alu_result);
         clock_and_read($sformatf("alu flags %0d op %0d %h %h", k, alu_op, alu_a, alu_b));
      end
   endtask

   task automatic priority_mix();
      // A cleared link makes a complement that wrongly beats the bus visible
      wait_drive_point();
      waddr   = flag_pkg::addr_flags_mbp;
      ibus_in = 16'h0000;
      clock_and_read("priority clear");
      // The bus gives V high and L low while the ALU gives zero with a carry
      wait_drive_point();
      waddr      = flag_pkg::addr_flags;
      ibus_in    = 16'h2000;
      action     = flag_pkg::action_cpl;
      alu_a      = 16'hffff;
      alu_b      = 16'h0001;
      alu_op     = flag_pkg::alu_op_add;
      alu_strobe = 1'b1;
      clock_and_read("priority write cpl alu");
      compare_values("priority byte", 16'h0028, ibus_out[15:8]);
      wait_drive_point();
      waddr   = flag_pkg::addr_flags_mbp;
      ibus_in = 16'h8000;
      clock_and_read("priority set i");
      wait_drive_point();
      waddr   = flag_pkg::addr_flags_mbp;
      ibus_in = 16'h0000;
      action  = flag_pkg::action_sti;
      clock_and_read("priority write over sti");
      compare_values("priority i", 16'd0, ibus_out[15]);
   endtask

   task automatic front_panel_lamps(input string name);
      wait_drive_point();
      nfpflags = 1'b0;
      wait_sample_point();
      compare_values({name, " lamps"}, model_byte(), fpd);
      check_bus_flags({name, " bus"});
      wait_drive_point();
      nfpflags = 1'b1;
      wait_sample_point();
      compare_values({name, " lamps off"}, 16'h0000, fpd);
   endtask

   //////////////////////////////
   // Sequence
   //////////////////////////////

   initial begin
      errors = 0;
      checks = 0;
      seed   = 32'hcd9a_5a0b;
      m_fn   = 1'b0;
      m_fz   = 1'b0;
      m_fl   = 1'b0;
      m_fv   = 1'b0;
      m_fi   = 1'b0;
      alu_a  = '0;
      alu_b  = '0;
      alu_op = flag_pkg::alu_op_add;
      rst_n  = 1'b0;
      idle_inputs(5'd0);
      repeat (4) @(posedge clk);
      #2 rst_n = 1'b1;
      check_reset_idle();
      bus_write_readback();
      front_panel_lamps("after writes");
      apply_actions();
      alu_flag_updates();
      priority_mix();
      front_panel_lamps("after priority");
      $display("Closing: %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* sim.f */
source/flag_pkg.sv
source/flag_unit.sv
source/flag_register.sv
source/alu_flag_gen.sv
source/flag_section.sv
testbench/flag_section_asserts.sv
testbench/tb_flag_section.sv

/* Bender.yml */
package:
  name: flag_section

sources:
  - files:
      - source/flag_pkg.sv
      - source/flag_unit.sv
      - source/flag_register.sv
      - source/alu_flag_gen.sv
      - source/flag_section.sv
  - target: simulation
    files:
      - testbench/flag_section_asserts.sv
      - testbench/tb_flag_section.sv
